//--- include/cdbus_defs.svh
`ifndef CDBUS_DEFS_SVH
`define CDBUS_DEFS_SVH

// Version byte read back at REG_VERSION.
`define CDBUS_VERSION 8'h08

`endif

//--- design/cdbus_pkg.sv
`default_nettype none

package cdbus_pkg;

    typedef enum logic [4:0] {
        REG_VERSION       = 5'h00,
        REG_SETTING       = 5'h01,
        REG_IDLE_WAIT_LEN = 5'h02,
        REG_FILTER        = 5'h04,
        REG_DIV_L         = 5'h05,
        REG_DIV_H         = 5'h06,
        REG_INT_FLAG      = 5'h09,
        REG_INT_MASK      = 5'h0a,
        REG_RX            = 5'h0b,
        REG_TX            = 5'h0c,
        REG_RX_CTRL       = 5'h0d,
        REG_TX_CTRL       = 5'h0e,
        REG_RX_ADDR       = 5'h0f,
        REG_RX_PAGE_FLAG  = 5'h10
    } reg_addr_e;

    localparam logic [7:0]  BROADCAST_ADDR = 8'hff;
    localparam logic [15:0] CRC_POLY       = 16'ha001; // Modbus, reflected.
    localparam int          CHAR_BITS      = 10;       // Start, 8 data, stop.

    // One byte of CRC-16, LSB first.
    function automatic logic [15:0] crc16_byte(input logic [15:0] crc, input logic [7:0] din);
        logic [15:0] c;
        c = crc ^ {8'h00, din};
        for (int i = 0; i < 8; i++) begin
            c = c[0] ? ((c >> 1) ^ CRC_POLY) : (c >> 1);
        end
        return c;
    endfunction

endpackage

`default_nettype wire

//--- design/pp_ram.sv
`timescale 1ns/10ps
`default_nettype none

module pp_ram #(
    parameter int N_WIDTH = 1
) (
    input  wire        clk,
    input  wire        reset_n,
    input  wire  [7:0] rd_addr,
    input  wire        rd_done,
    input  wire        rd_done_all,
    input  wire  [7:0] wr_byte,
    input  wire  [7:0] wr_addr,
    input  wire        wr_clk,
    input  wire        switch,
    input  wire  [7:0] wr_flags,
    output logic [7:0] rd_byte,
    output logic       unread,
    output logic [7:0] rd_flags,
    output logic       switch_fail
);
    localparam int PAGES = 1 << N_WIDTH;

    logic [7:0]         ram [PAGES * 256];
    logic [7:0]         flags [PAGES];
    logic [N_WIDTH-1:0] wr_sel;
    logic [N_WIDTH-1:0] rd_sel;  // Oldest pending page.
    logic [N_WIDTH:0]   pend;
    logic               full;
    logic               sw_ok;
    logic               rd_ok;

    // When every page is pending the write page is the oldest one, so writes stop.
    assign full = pend == (N_WIDTH + 1)'(PAGES);
    assign sw_ok = switch && !full;
    assign rd_ok = rd_done && unread;
    assign unread = pend != '0;
    assign switch_fail = switch && full;
    assign rd_byte = ram[{rd_sel, rd_addr}];
    assign rd_flags = flags[rd_sel];

    always_ff @(posedge clk) begin
        if (wr_clk && !full)
            ram[{wr_sel, wr_addr}] <= wr_byte;
        if (sw_ok)
            flags[wr_sel] <= wr_flags;
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            wr_sel <= '0;
            rd_sel <= '0;
            pend <= '0;
        end else if (rd_done_all) begin
            rd_sel <= wr_sel;
            pend <= '0;
        end else begin
            if (sw_ok)
                wr_sel <= wr_sel + 1'b1;
            if (rd_ok)
                rd_sel <= rd_sel + 1'b1;
            case ({sw_ok, rd_ok})
                2'b10:   pend <= pend + 1'b1;
                2'b01:   pend <= pend - 1'b1;
                default: pend <= pend;
            endcase
        end
    end

    // A new frame must not land while the host flushes every page.
    a_switch_vs_flush: assert property (@(posedge clk) disable iff (!reset_n)
        !(switch && rd_done_all));

endmodule

`default_nettype wire

//--- design/rx_des.sv
`timescale 1ns/10ps
`default_nettype none

module rx_des (
    input  wire         clk,
    input  wire         reset_n,
    input  wire  [15:0] div,
    input  wire  [7:0]  idle_wait_len,
    input  wire         force_wait_idle,
    input  wire         rx,
    output logic        bus_idle,
    output logic [7:0]  data,
    output logic [15:0] crc_data,
    output logic        data_clk
);
    typedef enum logic [1:0] {IDLE, START, BITS, STOP} state_e;

    state_e      state;
    logic [15:0] cnt;
    logic [3:0]  bit_cnt;
    logic [7:0]  shreg;
    logic [7:0]  idle_cnt;
    logic        tick;

    assign tick = cnt == 16'd0;

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            state <= IDLE;
            cnt <= 16'd0;
            bit_cnt <= 4'd0;
            idle_cnt <= 8'd0;
            bus_idle <= 1'b1;
            crc_data <= 16'hffff;
            data_clk <= 1'b0;
        end else begin
            data_clk <= 1'b0;
            cnt <= tick ? div : cnt - 16'd1;
            case (state)
                IDLE: begin
                    if (!rx) begin
                        state <= START;
                        cnt <= {1'b0, div[15:1]};  // Half a bit, to land mid-bit.
                        idle_cnt <= 8'd0;
                        bus_idle <= 1'b0;
                        if (bus_idle)
                            crc_data <= 16'hffff;  // New frame.
                    end else if (idle_cnt == idle_wait_len) begin
                        bus_idle <= 1'b1;
                    end else if (tick) begin
                        idle_cnt <= idle_cnt + 8'd1;
                    end
                end
                START: begin
                    if (tick) begin
                        state <= rx ? IDLE : BITS;  // Glitch goes back to idle.
                        bit_cnt <= 4'd1;
                    end
                end
                BITS: begin
                    if (tick) begin
                        bit_cnt <= bit_cnt + 4'd1;
                        if (bit_cnt == 4'(cdbus_pkg::CHAR_BITS - 2))
                            state <= STOP;
                    end
                end
                STOP: begin
                    if (tick) begin
                        state <= IDLE;
                        if (rx && !force_wait_idle) begin  // Bad stop bit drops the byte.
                            crc_data <= cdbus_pkg::crc16_byte(crc_data, shreg);
                            data_clk <= 1'b1;
                        end
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == BITS && tick)
            shreg <= {rx, shreg[7:1]};
        if (state == STOP && tick)
            data <= shreg;
    end

endmodule

`default_nettype wire

//--- design/rx_bytes.sv
`timescale 1ns/10ps
`default_nettype none

module rx_bytes (
    input  wire         clk,
    input  wire         reset_n,
    input  wire  [7:0]  filter,
    input  wire         abort,
    input  wire         bus_idle,
    input  wire  [7:0]  data,
    input  wire  [15:0] crc_data,
    input  wire         data_clk,
    output logic        error,
    output logic        force_wait_idle,
    output logic [7:0]  wr_byte,
    output logic [7:0]  wr_addr,
    output logic        wr_clk,
    output logic [7:0]  wr_flags,
    output logic        switch
);
    logic [7:0] byte_cnt;
    logic       bus_idle_d;
    logic       idle_rise;
    logic       frame_end;
    logic       dst_ok;

    assign idle_rise = bus_idle && !bus_idle_d;
    assign dst_ok = data == filter || data == cdbus_pkg::BROADCAST_ADDR;
    // Frame closes on the first cycle of bus idle.
    assign frame_end = idle_rise && byte_cnt != 8'd0 && !force_wait_idle && !abort;
    assign switch = frame_end && crc_data == 16'd0;  // CRC over data and CRC is zero.
    assign error = frame_end && crc_data != 16'd0;
    assign wr_flags = byte_cnt;

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            bus_idle_d <= 1'b1;
            byte_cnt <= 8'd0;
            wr_addr <= 8'd0;
            wr_clk <= 1'b0;
            force_wait_idle <= 1'b0;
        end else begin
            bus_idle_d <= bus_idle;
            wr_clk <= 1'b0;
            if (abort) begin
                byte_cnt <= 8'd0;
                force_wait_idle <= !bus_idle;  // Skip the rest of a frame in flight.
            end else if (idle_rise) begin
                byte_cnt <= 8'd0;
                force_wait_idle <= 1'b0;
            end else if (data_clk && !force_wait_idle) begin
                if (byte_cnt == 8'd1 && !dst_ok) begin
                    force_wait_idle <= 1'b1;  // Not for us.
                end else begin
                    wr_clk <= 1'b1;
                    wr_addr <= byte_cnt;
                    byte_cnt <= byte_cnt + 8'd1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (data_clk)
            wr_byte <= data;
    end

    // The last byte of a page must be the last byte of its frame.
    a_no_wrap: assert property (@(posedge clk) disable iff (!reset_n)
        (wr_clk && wr_addr == 8'hff) |=> (!wr_clk until bus_idle));

endmodule

`default_nettype wire

//--- design/tx_bytes_ser.sv
`timescale 1ns/10ps
`default_nettype none

module tx_bytes_ser (
    input  wire         clk,
    input  wire         reset_n,
    input  wire  [15:0] div,
    input  wire         unread,
    input  wire  [7:0]  data,
    input  wire         bus_idle,
    output logic [7:0]  addr,
    output logic        read_done,
    output logic        tx,
    output logic        tx_en
);
    typedef enum logic [2:0] {WAIT_IDLE, LOAD, SHIFT, CRC_L, CRC_H, DONE} state_e;

    state_e      state;
    logic [15:0] cnt;
    logic [3:0]  bit_cnt;
    logic [9:0]  sh;   // Stop, data, start; ones shift in behind.
    logic [7:0]  len;
    logic [15:0] crc;
    logic        tick;
    logic        char_end;

    assign tick = cnt == 16'd0;
    assign tx = sh[0];
    assign read_done = state == DONE;
    assign char_end = tick && bit_cnt == 4'(cdbus_pkg::CHAR_BITS - 1);

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            state <= WAIT_IDLE;
            cnt <= 16'd0;
            bit_cnt <= 4'd0;
            sh <= '1;
            len <= 8'd3;
            crc <= 16'hffff;
            addr <= 8'd0;
            tx_en <= 1'b0;
        end else begin
            cnt <= tick ? div : cnt - 16'd1;
            case (state)
                WAIT_IDLE: begin
                    if (unread && bus_idle) begin
                        state <= LOAD;
                        addr <= 8'd0;
                        len <= 8'd3;  // Real length known after the third byte.
                        crc <= 16'hffff;
                        tx_en <= 1'b1;
                    end
                end
                LOAD: begin
                    sh <= {1'b1, data, 1'b0};
                    crc <= cdbus_pkg::crc16_byte(crc, data);
                    if (addr == 8'd2)
                        len <= data + 8'd3;
                    bit_cnt <= 4'd0;
                    cnt <= div;
                    state <= SHIFT;
                end
                SHIFT, CRC_L, CRC_H: begin
                    if (tick) begin
                        sh <= {1'b1, sh[9:1]};
                        bit_cnt <= bit_cnt + 4'd1;
                    end
                    if (char_end) begin
                        bit_cnt <= 4'd0;
                        if (state == SHIFT) begin
                            addr <= addr + 8'd1;
                            state <= LOAD;
                            if (addr + 8'd1 == len) begin
                                sh <= {1'b1, crc[7:0], 1'b0};  // Low byte first.
                                state <= CRC_L;
                            end
                        end else if (state == CRC_L) begin
                            sh <= {1'b1, crc[15:8], 1'b0};
                            state <= CRC_H;
                        end else begin
                            state <= DONE;
                        end
                    end
                end
                DONE: begin
                    tx_en <= 1'b0;
                    state <= WAIT_IDLE;
                end
                default: state <= WAIT_IDLE;
            endcase
        end
    end

endmodule

`default_nettype wire

//--- design/cdbus.sv
`timescale 1ns/10ps
`default_nettype none

`include "cdbus_defs.svh"

module cdbus #(
    parameter logic [15:0] DIV = 16'd346  // Baud = clk / (DIV + 1).
) (
    input  wire        clk,
    input  wire        reset_n,
    input  wire  [4:0] csr_address,
    input  wire        csr_read,
    input  wire        csr_write,
    input  wire  [7:0] csr_writedata,
    input  wire        rx,
    output logic [7:0] csr_readdata,
    output logic       irq,
    output logic       tx,
    output logic       tx_en
);
    logic        tx_en_on;
    logic [7:0]  idle_wait_len;
    logic [7:0]  filter;
    logic [15:0] div;
    logic [6:0]  int_mask;
    logic [6:0]  int_flag;
    logic        rx_error_flag;
    logic        rx_lost_flag;
    logic        rx_pending;
    logic        tx_pending;
    logic        bus_idle;
    logic        rx_pipe;
    logic        rx_d;

    logic [7:0]  rx_ram_rd_addr;
    logic [7:0]  rx_ram_rd_data;
    logic [7:0]  rx_ram_rd_flags;
    logic        rx_ram_rd_done;
    logic        rx_clean_all;
    logic        rx_ram_lost;
    logic        rx_error;
    logic [7:0]  rx_ram_wr_byte;
    logic [7:0]  rx_ram_wr_addr;
    logic        rx_ram_wr_clk;
    logic [7:0]  rx_ram_wr_flags;
    logic        rx_ram_switch;

    logic [7:0]  tx_ram_wr_addr;
    logic        tx_ram_wr_clk;
    logic        tx_ram_switch;
    logic [7:0]  tx_addr;
    logic [7:0]  tx_data;
    logic        tx_read_done;
    logic        tx_en_ser;

    logic [7:0]  des_data;
    logic [15:0] des_crc_data;
    logic        des_data_clk;
    logic        force_wait_idle;

    assign int_flag = {1'b0, 1'b0, ~tx_pending, rx_error_flag, rx_lost_flag,
                       rx_pending, bus_idle};
    assign irq = |(int_flag & int_mask);
    assign tx_en = tx_en_ser && tx_en_on;
    assign tx_ram_wr_clk = csr_write && csr_address == cdbus_pkg::REG_TX;

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n)
            {rx_d, rx_pipe} <= 2'b11;
        else
            {rx_d, rx_pipe} <= {rx_pipe, rx};
    end

    always_comb begin
        case (csr_address)
            cdbus_pkg::REG_VERSION:       csr_readdata = `CDBUS_VERSION;
            cdbus_pkg::REG_SETTING:       csr_readdata = {7'd0, tx_en_on};
            cdbus_pkg::REG_IDLE_WAIT_LEN: csr_readdata = idle_wait_len;
            cdbus_pkg::REG_FILTER:        csr_readdata = filter;
            cdbus_pkg::REG_DIV_L:         csr_readdata = div[7:0];
            cdbus_pkg::REG_DIV_H:         csr_readdata = div[15:8];
            cdbus_pkg::REG_INT_FLAG:      csr_readdata = {1'b0, int_flag};
            cdbus_pkg::REG_INT_MASK:      csr_readdata = {1'b0, int_mask};
            cdbus_pkg::REG_RX:            csr_readdata = rx_ram_rd_data;
            cdbus_pkg::REG_RX_ADDR:       csr_readdata = rx_ram_rd_addr;
            cdbus_pkg::REG_RX_PAGE_FLAG:  csr_readdata = rx_ram_rd_flags;
            default:                      csr_readdata = 8'd0;
        endcase
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            tx_en_on <= 1'b0;
            idle_wait_len <= 8'd10;  // One character.
            filter <= 8'hff;
            div <= DIV;
            int_mask <= 7'd0;
            rx_error_flag <= 1'b0;
            rx_lost_flag <= 1'b0;
            rx_ram_rd_addr <= 8'd0;
            rx_ram_rd_done <= 1'b0;
            rx_clean_all <= 1'b0;
            tx_ram_wr_addr <= 8'd0;
            tx_ram_switch <= 1'b0;
        end else begin
            rx_ram_rd_done <= 1'b0;
            rx_clean_all <= 1'b0;
            tx_ram_switch <= 1'b0;
            if (rx_error)
                rx_error_flag <= 1'b1;
            if (rx_ram_lost)
                rx_lost_flag <= 1'b1;
            if (csr_read && csr_address == cdbus_pkg::REG_RX)
                rx_ram_rd_addr <= rx_ram_rd_addr + 8'd1;
            if (csr_write) begin
                case (csr_address)
                    cdbus_pkg::REG_SETTING:       tx_en_on <= csr_writedata[0];
                    cdbus_pkg::REG_IDLE_WAIT_LEN: idle_wait_len <= csr_writedata;
                    cdbus_pkg::REG_FILTER:        filter <= csr_writedata;
                    cdbus_pkg::REG_DIV_L:         div[7:0] <= csr_writedata;
                    cdbus_pkg::REG_DIV_H:         div[15:8] <= csr_writedata;
                    cdbus_pkg::REG_INT_MASK:      int_mask <= csr_writedata[6:0];
                    cdbus_pkg::REG_TX:            tx_ram_wr_addr <= tx_ram_wr_addr + 8'd1;
                    cdbus_pkg::REG_RX_ADDR:       rx_ram_rd_addr <= csr_writedata;
                    cdbus_pkg::REG_RX_CTRL: begin
                        if (csr_writedata[4]) begin  // Flush everything.
                            rx_ram_rd_addr <= 8'd0;
                            rx_clean_all <= 1'b1;
                        end else if (csr_writedata[1] || csr_writedata[0]) begin
                            rx_ram_rd_addr <= 8'd0;
                            rx_ram_rd_done <= csr_writedata[1];
                        end
                        if (csr_writedata[2] || csr_writedata[4])
                            rx_lost_flag <= 1'b0;
                        if (csr_writedata[3] || csr_writedata[4])
                            rx_error_flag <= 1'b0;
                    end
                    cdbus_pkg::REG_TX_CTRL: begin
                        if (csr_writedata[1] || csr_writedata[0])
                            tx_ram_wr_addr <= 8'd0;
                        tx_ram_switch <= csr_writedata[1];
                    end
                    default: ;
                endcase
            end
        end
    end

    a_csr_exclusive: assert property (@(posedge clk) disable iff (!reset_n)
        !(csr_read && csr_write));

    pp_ram #(.N_WIDTH(2)) pp_ram_rx_m (
        .clk(clk), .reset_n(reset_n),
        .rd_addr(rx_ram_rd_addr), .rd_done(rx_ram_rd_done), .rd_done_all(rx_clean_all),
        .wr_byte(rx_ram_wr_byte), .wr_addr(rx_ram_wr_addr), .wr_clk(rx_ram_wr_clk),
        .switch(rx_ram_switch), .wr_flags(rx_ram_wr_flags),
        .rd_byte(rx_ram_rd_data), .unread(rx_pending), .rd_flags(rx_ram_rd_flags),
        .switch_fail(rx_ram_lost)
    );

    pp_ram #(.N_WIDTH(1)) pp_ram_tx_m (
        .clk(clk), .reset_n(reset_n),
        .rd_addr(tx_addr), .rd_done(tx_read_done), .rd_done_all(1'b0),
        .wr_byte(csr_writedata), .wr_addr(tx_ram_wr_addr), .wr_clk(tx_ram_wr_clk),
        .switch(tx_ram_switch), .wr_flags(8'd0),
        .rd_byte(tx_data), .unread(tx_pending), .rd_flags(), .switch_fail()
    );

    rx_des rx_des_m (
        .clk(clk), .reset_n(reset_n),
        .div(div), .idle_wait_len(idle_wait_len), .force_wait_idle(force_wait_idle),
        .rx(rx_d), .bus_idle(bus_idle),
        .data(des_data), .crc_data(des_crc_data), .data_clk(des_data_clk)
    );

    rx_bytes rx_bytes_m (
        .clk(clk), .reset_n(reset_n),
        .filter(filter), .abort(rx_clean_all), .bus_idle(bus_idle),
        .data(des_data), .crc_data(des_crc_data), .data_clk(des_data_clk),
        .error(rx_error), .force_wait_idle(force_wait_idle),
        .wr_byte(rx_ram_wr_byte), .wr_addr(rx_ram_wr_addr), .wr_clk(rx_ram_wr_clk),
        .wr_flags(rx_ram_wr_flags), .switch(rx_ram_switch)
    );

    tx_bytes_ser tx_bytes_ser_m (
        .clk(clk), .reset_n(reset_n),
        .div(div), .unread(tx_pending), .data(tx_data), .bus_idle(bus_idle),
        .addr(tx_addr), .read_done(tx_read_done), .tx(tx), .tx_en(tx_en_ser)
    );

endmodule

`default_nettype wire

//--- sim/cdbus_tb.sv
`timescale 1ns/10ps
`default_nettype none

`include "cdbus_defs.svh"

module cdbus_tb;
    localparam logic [15:0] DIV = 16'd7;
    localparam int BIT_CYCLES = DIV + 1;
    localparam int RX_PAGES = 4;
    localparam int N_FRAMES = 13;
    // Budget of 40 characters per frame, plus margin for register traffic.
    localparam int MAX_CYCLES = N_FRAMES * 40 * 10 * BIT_CYCLES + 18400;

    logic        clk;
    logic        reset_n;
    logic [4:0]  csr_address;
    logic        csr_read;
    logic        csr_write;
    logic [7:0]  csr_writedata;
    wire  [7:0]  csr_readdata;
    wire         irq;
    wire         tx;
    wire         tx_en;
    wire         rx;
    logic        inj_sel;
    logic        inj_line;

    integer      seed;
    int          errors = 0;
    int          checks = 0;
    int          cycles = 0;
    logic [31:0] rnd;
    logic [7:0]  filter;
    logic [7:0]  rdata;
    logic [7:0]  frame [$];      // Frame being sent, CRC included.
    logic [7:0]  exp_bytes [$];  // Model of the pending receive pages.
    int          exp_lens [$];
    logic        model_lost;
    logic        model_err;

    assign rx = inj_sel ? inj_line : tx;  // Loopback unless injecting.

    cdbus #(.DIV(DIV)) i_cdbus (
        .clk(clk), .reset_n(reset_n),
        .csr_address(csr_address), .csr_read(csr_read), .csr_write(csr_write),
        .csr_writedata(csr_writedata), .csr_readdata(csr_readdata),
        .rx(rx), .irq(irq), .tx(tx), .tx_en(tx_en)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= MAX_CYCLES) begin
            $display("Timeout: the run did not finish within %0d cycles.", MAX_CYCLES);
            $display("*** FAILED ***");
            $finish;
        end
    end

    // Bitwise Modbus CRC, reflected form.
    function automatic logic [15:0] crc_next(input logic [15:0] crc, input logic [7:0] b);
        logic [15:0] c;
        logic        fb;
        c = crc;
        for (int i = 0; i < 8; i++) begin
            fb = c[0] ^ b[i];
            c = c >> 1;
            if (fb)
                c = c ^ cdbus_pkg::CRC_POLY;
        end
        return c;
    endfunction

    task automatic step();
        @(posedge clk);
        #10;
    endtask

    task automatic check_val(input string name, input logic [7:0] got, input logic [7:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Error: %s is %h, expected %h", name, got, exp);
        end
    endtask

    // Transmit enable must be up for every low bit on tx.
    always @(negedge clk) begin
        if (reset_n && !tx)
            check_val("tx_en", {7'd0, tx_en}, 8'h01);
    end

    task automatic reg_write(input logic [4:0] addr, input logic [7:0] data);
        csr_address = addr;
        csr_writedata = data;
        csr_write = 1'b1;
        step();
        csr_write = 1'b0;
    endtask

    task automatic reg_read(input logic [4:0] addr, output logic [7:0] data);
        csr_address = addr;
        csr_read = 1'b1;
        @(negedge clk);
        data = csr_readdata;  // Mid-cycle, well away from the edge.
        step();
        csr_read = 1'b0;
    endtask

    task automatic build_frame(input logic [7:0] dst);
        logic [31:0] r;
        logic [15:0] crc;
        logic [7:0]  len;
        r = $random(seed);
        len = {4'd0, r[3:0]};
        frame.delete();
        frame.push_back(r[15:8]);  // Source.
        frame.push_back(dst);
        frame.push_back(len);
        for (int i = 0; i < int'(len); i++) begin
            r = $random(seed);
            frame.push_back(r[7:0]);
        end
        crc = 16'hffff;
        foreach (frame[i])
            crc = crc_next(crc, frame[i]);
        frame.push_back(crc[7:0]);  // Low byte first.
        frame.push_back(crc[15:8]);
    endtask

    task automatic model_receive(input logic crc_ok);
        if (frame[1] == filter || frame[1] == cdbus_pkg::BROADCAST_ADDR) begin
            if (!crc_ok) begin
                model_err = 1'b1;
            end else if (exp_lens.size() == RX_PAGES) begin
                model_lost = 1'b1;
            end else begin
                exp_lens.push_back(frame.size());
                foreach (frame[i])
                    exp_bytes.push_back(frame[i]);
            end
        end
    endtask

    // Wait for the transmit page to drain and the bus to go idle.
    task automatic wait_frame_end();
        logic [7:0] f;
        repeat (4) step();
        f = 8'h00;
        while ((f & 8'h11) != 8'h11)
            reg_read(cdbus_pkg::REG_INT_FLAG, f);
        repeat (4) step();
    endtask

    task automatic send_frame(input logic [7:0] dst);
        build_frame(dst);
        for (int i = 0; i < frame.size() - 2; i++)
            reg_write(cdbus_pkg::REG_TX, frame[i]);
        reg_write(cdbus_pkg::REG_TX_CTRL, 8'h02);  // Release the page.
        model_receive(1'b1);
        wait_frame_end();
        check_val("tx_en", {7'd0, tx_en}, 8'h00);
    endtask

    task automatic inject_bad_frame();
        logic [9:0] ch;
        build_frame(filter);
        frame[frame.size() - 2] = frame[frame.size() - 2] ^ 8'h01;
        inj_sel = 1'b1;
        foreach (frame[i]) begin
            ch = {1'b1, frame[i], 1'b0};
            for (int b = 0; b < cdbus_pkg::CHAR_BITS; b++) begin
                inj_line = ch[b];
                repeat (BIT_CYCLES) step();
            end
        end
        inj_sel = 1'b0;
        model_receive(1'b0);
        wait_frame_end();
    endtask

    task automatic check_flags();
        reg_read(cdbus_pkg::REG_INT_FLAG, rdata);
        check_val("int_flag", rdata,
                  {4'b0001, model_err, model_lost, exp_lens.size() != 0, 1'b1});
    endtask

    task automatic read_page();
        int n;
        n = exp_lens.pop_front();
        reg_read(cdbus_pkg::REG_RX_PAGE_FLAG, rdata);
        check_val("rx_page_flag", rdata, n[7:0]);
        for (int i = 0; i < n; i++) begin
            reg_read(cdbus_pkg::REG_RX, rdata);
            check_val("rx_data", rdata, exp_bytes.pop_front());
        end
        reg_write(cdbus_pkg::REG_RX_CTRL, 8'h02);  // Page done.
        step();
    endtask

    initial begin
        seed = 32'hc6fe;
        reset_n = 1'b0;
        csr_address = 5'd0;
        csr_read = 1'b0;
        csr_write = 1'b0;
        csr_writedata = 8'd0;
        inj_sel = 1'b0;
        inj_line = 1'b1;
        model_lost = 1'b0;
        model_err = 1'b0;
        repeat (3) @(posedge clk);
        #10;
        reset_n = 1'b1;
        step();

        check_val("tx", {7'd0, tx}, 8'h01);
        check_val("tx_en", {7'd0, tx_en}, 8'h00);
        check_val("irq", {7'd0, irq}, 8'h00);
        reg_read(cdbus_pkg::REG_VERSION, rdata);
        check_val("version", rdata, `CDBUS_VERSION);
        reg_read(cdbus_pkg::REG_DIV_L, rdata);
        check_val("div_l", rdata, DIV[7:0]);
        reg_read(cdbus_pkg::REG_DIV_H, rdata);
        check_val("div_h", rdata, DIV[15:8]);
        check_flags();

        // Unicast filter, top bit clear so a mismatch can never be broadcast.
        rnd = $random(seed);
        filter = {1'b0, rnd[6:0]};
        reg_write(cdbus_pkg::REG_FILTER, filter);
        reg_write(cdbus_pkg::REG_SETTING, 8'h01);
        repeat (4) begin
            send_frame(filter);
            check_flags();
            read_page();
            check_flags();
        end

        send_frame(filter ^ 8'h40);  // Not for us.
        check_flags();
        send_frame(cdbus_pkg::BROADCAST_ADDR);
        check_flags();
        read_page();
        check_flags();

        inject_bad_frame();
        check_flags();
        reg_write(cdbus_pkg::REG_RX_CTRL, 8'h08);
        model_err = 1'b0;
        check_flags();

        // Fill every page, then one more.
        repeat (RX_PAGES + 1)
            send_frame(filter);
        check_flags();
        repeat (RX_PAGES)
            read_page();
        reg_write(cdbus_pkg::REG_RX_CTRL, 8'h04);
        model_lost = 1'b0;
        check_flags();

        reg_write(cdbus_pkg::REG_INT_MASK, 8'h02);  // rx_pending only.
        check_val("irq", {7'd0, irq}, 8'h00);
        send_frame(filter);
        check_val("irq", {7'd0, irq}, 8'h01);
        reg_write(cdbus_pkg::REG_INT_MASK, 8'h00);
        check_val("irq", {7'd0, irq}, 8'h00);
        reg_write(cdbus_pkg::REG_INT_MASK, 8'h02);
        check_val("irq", {7'd0, irq}, 8'h01);
        read_page();
        check_val("irq", {7'd0, irq}, 8'h00);
        check_flags();

        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0)
            $display("*** PASSED ***");
        else
            $display("*** FAILED ***");
        $finish;
    end

endmodule

`default_nettype wire

//--- cdbus.f
+incdir+include
design/cdbus_pkg.sv
design/pp_ram.sv
design/rx_des.sv
design/rx_bytes.sv
design/tx_bytes_ser.sv
design/cdbus.sv
sim/cdbus_tb.sv

//--- Makefile
# Verilator flow for the CDBUS controller.

TOP       ?= cdbus_tb
FILELIST  ?= cdbus.f
OBJ_DIR   ?= obj_dir
VERILATOR ?= verilator
VFLAGS    ?= --timing --assert
PASS_MSG  ?= *** PASSED ***

SOURCES := $(shell grep -v '^+' $(FILELIST)) $(wildcard include/*.svh)

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

$(OBJ_DIR)/V$(TOP): $(SOURCES) $(FILELIST)
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

sim: $(OBJ_DIR)/V$(TOP)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF '$(PASS_MSG)'

clean:
	rm -rf $(OBJ_DIR)
